// File: verilog/dma_fifo_pkg.sv
// Geometry constants of the SCSI DMA longword FIFO
// Byte pointer preset values and the lane-mask type

package dma_fifo_pkg;

  // Longword storage
  localparam int WORD_W     = 32;  // One longword
  localparam int FIFO_DEPTH = 8;   // Longwords held
  localparam int PTR_W      = 3;   // Next-in / next-out pointer width
  localparam int CNT_W      = 4;   // Occupancy count, must hold FIFO_DEPTH

  // Byte lanes
  localparam int LANES  = 4;              // Bytes per longword
  localparam int BYTE_W = WORD_W / LANES; // Width of one lane
  localparam int BPTR_W = 2;              // Byte pointer width

  // Byte pointer values loaded by clear and by the ACR write
  localparam logic [BPTR_W-1:0] BPTR_START = 2'd0;  // First byte, bits 31:24
  localparam logic [BPTR_W-1:0] BPTR_MID25 = 2'd2;  // Transfer starts on odd word

  // Lane write enables, big-endian
  //   bit 3 -> bits 31:24
  //   bit 2 -> bits 23:16
  //   bit 1 -> bits 15:8
  //   bit 0 -> bits 7:0
  typedef logic [LANES-1:0] lane_mask_t;

  // Lanes covered by the CPU half-word loads
  localparam lane_mask_t LANES_HIGH = 4'b1100;  // lhword
  localparam lane_mask_t LANES_LOW  = 4'b0011;  // llword

endpackage

// File: verilog/fifo_lane_decode.sv
// Byte pointer with ACR preset, increment and clears
// Decode of the CPU word loads and the SCSI byte load into lane write enables

`timescale 1ns/1ps

module fifo_lane_decode (
  input  logic                            LLWS,       // FIFO clock
  input  logic                            rst_n,      // Sync reset, active low
  input  logic                            rst_fifo_n, // Controller FIFO clear
  input  logic                            llword,     // CPU loads bits 15:0
  input  logic                            lhword,     // CPU loads bits 31:16
  input  logic                            lbyte_n,    // SCSI byte load, active low
  input  logic                            inc_bo,     // Step to next byte lane
  input  logic                            acr_wr,     // Control register write
  input  logic                            h_0c,       // Address decode for $0C
  input  logic                            mid25,      // Preset to the lower half-word
  output logic [dma_fifo_pkg::BPTR_W-1:0] byte_ptr,   // Current byte lane
  output dma_fifo_pkg::lane_mask_t        lane_we     // Per-lane write enables
);

  import dma_fifo_pkg::*;

  logic              acr_load;    // ACR write hits $0C
  logic [BPTR_W-1:0] preset_val;  // Value the ACR write loads
  lane_mask_t        word_lanes;  // Lanes from the half-word loads
  lane_mask_t        byte_lanes;  // Lane from the byte load

  // ACR preset
  assign acr_load   = acr_wr & h_0c;
  assign preset_val = mid25 ? BPTR_MID25 : BPTR_START;

  // Byte pointer register
  // Preset has priority over the increment, both clears over everything
  always_ff @(posedge LLWS) begin
    if (!rst_n || !rst_fifo_n) begin
      byte_ptr <= BPTR_START;
    end else if (acr_load) begin
      byte_ptr <= preset_val;
    end else if (inc_bo) begin
      byte_ptr <= byte_ptr + 1'b1;  // Wraps from 3 back to 0
    end
  end

  // Half-word loads each cover two lanes
  always_comb begin
    word_lanes = '0;
    if (lhword) begin
      word_lanes = word_lanes | LANES_HIGH;  // Bits 31:16
    end
    if (llword) begin
      word_lanes = word_lanes | LANES_LOW;   // Bits 15:0
    end
  end

  // Byte load goes to lane 3 - byte_ptr
  // Pointer 0 is the most significant byte
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      byte_lanes[l] = !lbyte_n && (byte_ptr == BPTR_W'(LANES - 1 - l));
    end
  end

  // Sources can overlap in one cycle; the store sees the union
  // Decode uses the pointer before any update on this edge
  assign lane_we = word_lanes | byte_lanes;

endmodule

// File: verilog/fifo_store.sv
// Eight-longword storage array with byte-lane writes
// Next-in and next-out pointers, unregistered read of the next-out word

`timescale 1ns/1ps

module fifo_store (
  input  logic                            LLWS,       // FIFO clock
  input  logic                            rst_n,      // Sync reset, active low
  input  logic                            rst_fifo_n, // Controller FIFO clear
  input  dma_fifo_pkg::lane_mask_t        lane_we,    // Lanes to write this edge
  input  logic                            inc_ni,     // Advance next-in
  input  logic                            inc_no,     // Advance next-out
  input  logic [dma_fifo_pkg::WORD_W-1:0] id,         // Write data
  output logic [dma_fifo_pkg::WORD_W-1:0] od          // Word at next-out
);

  import dma_fifo_pkg::*;

  logic [WORD_W-1:0] mem [FIFO_DEPTH];  // Longword buffer, no reset
  logic [PTR_W-1:0]  next_in;           // Write address
  logic [PTR_W-1:0]  next_out;          // Read address

  // Next-in pointer
  // Depth is a power of two so the pointer wraps on its own
  always_ff @(posedge LLWS) begin
    if (!rst_n || !rst_fifo_n) begin
      next_in <= '0;
    end else if (inc_ni) begin
      next_in <= next_in + 1'b1;
    end
  end

  // Next-out pointer
  always_ff @(posedge LLWS) begin
    if (!rst_n || !rst_fifo_n) begin
      next_out <= '0;
    end else if (inc_no) begin
      next_out <= next_out + 1'b1;
    end
  end

  // Lane writes at the current next-in address
  // A write together with inc_ni still lands in the old slot
  always_ff @(posedge LLWS) begin
    for (int l = 0; l < LANES; l++) begin
      if (lane_we[l]) begin
        mem[next_in][l*BYTE_W +: BYTE_W] <= id[l*BYTE_W +: BYTE_W];
      end
    end
  end

  // Read port
  // No output register, so after an inc_no edge od already
  // shows the following word in that cycle
  assign od = mem[next_out];

endmodule

// File: verilog/fifo_occupancy.sv
// Longword occupancy counter
// Full and empty flags decoded from the registered count

`timescale 1ns/1ps

module fifo_occupancy (
  input  logic LLWS,       // FIFO clock
  input  logic rst_n,      // Sync reset, active low
  input  logic rst_fifo_n, // Controller FIFO clear
  input  logic inc_fifo,   // One longword added
  input  logic dec_fifo,   // One longword removed
  output logic fifo_full,  // Count at FIFO_DEPTH
  output logic fifo_empty  // Count at zero
);

  import dma_fifo_pkg::*;

  logic [CNT_W-1:0] count;    // Longwords held, 0 to FIFO_DEPTH
  logic             do_inc;   // Accepted increment
  logic             do_dec;   // Accepted decrement

  // Both strobes together cancel out
  // Steps past the limits are dropped, tied to the flags
  assign do_inc = inc_fifo && !dec_fifo && !fifo_full;
  assign do_dec = dec_fifo && !inc_fifo && !fifo_empty;

  always_ff @(posedge LLWS) begin
    if (!rst_n || !rst_fifo_n) begin
      count <= '0;
    end else if (do_inc) begin
      count <= count + 1'b1;
    end else if (do_dec) begin
      count <= count - 1'b1;
    end
  end

  // Flags follow the count one edge after the strobe
  assign fifo_full  = (count == CNT_W'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);

endmodule

// File: verilog/dma_fifo.sv
// Top level of the SCSI DMA longword FIFO
// Connects lane decode, storage and occupancy; byte pointer status outputs

`timescale 1ns/1ps

module dma_fifo (
  input  logic                            LLWS,       // FIFO clock
  input  logic                            rst_n,      // Sync reset, active low
  input  logic                            rst_fifo_n, // FIFO clear from controller
  input  logic                            llword,     // CPU load, lower half-word
  input  logic                            lhword,     // CPU load, higher half-word
  input  logic                            lbyte_n,    // SCSI byte load, active low
  input  logic                            inc_bo,     // Byte pointer increment
  input  logic                            acr_wr,     // Control register write
  input  logic                            h_0c,       // Address decode for $0C
  input  logic                            mid25,      // ACR preset select
  input  logic                            inc_fifo,   // Count up
  input  logic                            dec_fifo,   // Count down
  input  logic                            inc_ni,     // Next-in advance
  input  logic                            inc_no,     // Next-out advance
  input  logic [dma_fifo_pkg::WORD_W-1:0] id,         // Data in
  output logic                            fifo_full,  // Eight longwords held
  output logic                            fifo_empty, // Nothing held
  output logic                            boeq0,      // Pointer on first byte
  output logic                            boeq3,      // Pointer on fourth byte
  output logic                            bo0,        // Byte pointer bit 0
  output logic                            bo1,        // Byte pointer bit 1
  output logic [dma_fifo_pkg::WORD_W-1:0] od          // Data out, next-out word
);

  import dma_fifo_pkg::*;

  logic [BPTR_W-1:0] byte_ptr;  // Current SCSI byte lane
  lane_mask_t        lane_we;   // Decoder to store

  // Decode: byte pointer and lane enables
  fifo_lane_decode u_decode (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .llword     (llword),
    .lhword     (lhword),
    .lbyte_n    (lbyte_n),
    .inc_bo     (inc_bo),
    .acr_wr     (acr_wr),
    .h_0c       (h_0c),
    .mid25      (mid25),
    .byte_ptr   (byte_ptr),
    .lane_we    (lane_we)
  );

  // Execute: array and its pointers
  fifo_store u_store (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .lane_we    (lane_we),
    .inc_ni     (inc_ni),
    .inc_no     (inc_no),
    .id         (id),
    .od         (od)
  );

  // Result: longword count and flags
  fifo_occupancy u_occupancy (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .inc_fifo   (inc_fifo),
    .dec_fifo   (dec_fifo),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  // Byte pointer status for the SCSI state machine
  assign bo0   = byte_ptr[0];
  assign bo1   = byte_ptr[1];
  assign boeq0 = (byte_ptr == BPTR_START);     // About to load bits 31:24
  assign boeq3 = (byte_ptr == BPTR_W'(LANES - 1)); // Last byte of the longword

endmodule

// File: test/tb_fifo_model.svh
// Reference functions for the DMA FIFO model
// Lane masks, word merging, byte pointer and count updates

`ifndef TB_FIFO_MODEL_SVH
`define TB_FIFO_MODEL_SVH

// Expand a lane mask to a 32-bit bit mask, bit 3 -> bits 31:24
function automatic logic [WORD_W-1:0] lane_bits(lane_mask_t m);
  return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

// Lanes written for a set of load strobes
function automatic lane_mask_t lane_mask(logic lw, logic hw, logic lb_n,
                                         logic [BPTR_W-1:0] bp);
  lane_mask_t m;
  m = '0;
  if (hw) m = m | 4'b1100;  // Bits 31:16
  if (lw) m = m | 4'b0011;  // Bits 15:0
  if (!lb_n) m = m | (lane_mask_t'(4'b1000) >> bp);  // Pointer 0 is the top byte
  return m;
endfunction

// New data into the enabled lanes, old data elsewhere
function automatic logic [WORD_W-1:0] merge_word(logic [WORD_W-1:0] old_w,
                                                 logic [WORD_W-1:0] new_w, lane_mask_t m);
  logic [WORD_W-1:0] bits;
  bits = lane_bits(m);
  return (old_w & ~bits) | (new_w & bits);
endfunction

// ACR load beats the increment
function automatic logic [BPTR_W-1:0] next_byte_ptr(logic [BPTR_W-1:0] bp,
                                                    logic acr_load, logic mid, logic inc);
  if (acr_load) return mid ? 2'd2 : 2'd0;
  if (inc) return bp + 2'd1;  // Modulo 4
  return bp;
endfunction

// Saturating count, both strobes cancel
function automatic logic [CNT_W-1:0] next_count(logic [CNT_W-1:0] cnt, logic inc, logic dec);
  if (inc && !dec && cnt != CNT_W'(FIFO_DEPTH)) return cnt + 1'b1;
  if (dec && !inc && cnt != '0) return cnt - 1'b1;
  return cnt;
endfunction

`endif

// File: test/tb_dma_fifo.sv
// Testbench for the SCSI DMA longword FIFO
// Clock, reset, LFSR data, directed tests, model compare and timeout

`timescale 1ns/1ps

module tb_dma_fifo;

  import dma_fifo_pkg::*;

  `include "tb_fifo_model.svh"

  localparam int TEST_CYCLES    = 300;              // Generous bound on the sequence
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  // DUT signals
  logic              LLWS;
  logic              rst_n;
  logic              rst_fifo_n;
  logic              llword;
  logic              lhword;
  logic              lbyte_n;
  logic              inc_bo;
  logic              acr_wr;
  logic              h_0c;
  logic              mid25;
  logic              inc_fifo;
  logic              dec_fifo;
  logic              inc_ni;
  logic              inc_no;
  logic [WORD_W-1:0] id;
  logic              fifo_full;
  logic              fifo_empty;
  logic              boeq0;
  logic              boeq3;
  logic              bo0;
  logic              bo1;
  logic [WORD_W-1:0] od;

  // Model state
  logic [WORD_W-1:0] m_mem [FIFO_DEPTH];
  lane_mask_t        m_known [FIFO_DEPTH];  // Lanes written since power-up
  logic [PTR_W-1:0]  m_ni;
  logic [PTR_W-1:0]  m_no;
  logic [CNT_W-1:0]  m_cnt;
  logic [BPTR_W-1:0] m_bptr;

  // Bookkeeping
  string       test_name = "reset";
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [15:0] lfsr_state = 16'd26;  // Seed

  dma_fifo u_dut (
    .LLWS       (LLWS),
    .rst_n      (rst_n),
    .rst_fifo_n (rst_fifo_n),
    .llword     (llword),
    .lhword     (lhword),
    .lbyte_n    (lbyte_n),
    .inc_bo     (inc_bo),
    .acr_wr     (acr_wr),
    .h_0c       (h_0c),
    .mid25      (mid25),
    .inc_fifo   (inc_fifo),
    .dec_fifo   (dec_fifo),
    .inc_ni     (inc_ni),
    .inc_no     (inc_no),
    .id         (id),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .boeq0      (boeq0),
    .boeq3      (boeq3),
    .bo0        (bo0),
    .bo1        (bo1),
    .od         (od)
  );

  initial begin
    LLWS = 1'b0;
    forever #10 LLWS = ~LLWS;  // 20 ns period
  end

  always @(posedge LLWS) cycle_count <= cycle_count + 1;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[15]};
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (exp === act) else begin
      error_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    assert (exp === act) else begin
      error_count++;
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // All strobes inactive
  // lbyte_n and rst_fifo_n are active low
  task automatic drive_idle();
    llword     = 1'b0;
    lhword     = 1'b0;
    lbyte_n    = 1'b1;
    inc_bo     = 1'b0;
    acr_wr     = 1'b0;
    h_0c       = 1'b0;
    mid25      = 1'b0;
    inc_fifo   = 1'b0;
    dec_fifo   = 1'b0;
    inc_ni     = 1'b0;
    inc_no     = 1'b0;
    rst_fifo_n = 1'b1;
  endtask

  // Strobes set by the caller are sampled on this edge and then dropped
  task automatic step_cycle();
    @(posedge LLWS);
    #2;
    drive_idle();
  endtask

  // Whole longword into the next-in slot, counted
  task automatic push_word(input logic [WORD_W-1:0] data);
    id       = data;
    lhword   = 1'b1;
    llword   = 1'b1;
    inc_ni   = 1'b1;
    inc_fifo = 1'b1;
    step_cycle();
  endtask

  // Drop the next-out word
  task automatic pop_word();
    inc_no   = 1'b1;
    dec_fifo = 1'b1;
    step_cycle();
  endtask

  // Model follows the same edge rules as the FIFO
  task automatic update_model();
    lane_mask_t we;
    we = lane_mask(llword, lhword, lbyte_n, m_bptr);
    m_mem[m_ni]   = merge_word(m_mem[m_ni], id, we);  // Storage ignores both clears
    m_known[m_ni] = m_known[m_ni] | we;
    if (!rst_n || !rst_fifo_n) begin
      m_ni   = '0;
      m_no   = '0;
      m_cnt  = '0;
      m_bptr = 2'd0;
    end else begin
      if (inc_ni) m_ni = m_ni + 1'b1;
      if (inc_no) m_no = m_no + 1'b1;
      m_cnt  = next_count(m_cnt, inc_fifo, dec_fifo);
      m_bptr = next_byte_ptr(m_bptr, acr_wr && h_0c, mid25, inc_bo);
    end
  endtask

  task automatic compare_outputs();
    logic [WORD_W-1:0] keep;
    keep = lane_bits(m_known[m_no]);  // Unwritten lanes are undefined
    check_word("od", m_mem[m_no] & keep, od & keep);
    check_bit("fifo_full", m_cnt == CNT_W'(FIFO_DEPTH), fifo_full);
    check_bit("fifo_empty", m_cnt == '0, fifo_empty);
    check_bit("bo0", m_bptr[0], bo0);
    check_bit("bo1", m_bptr[1], bo1);
    check_bit("boeq0", m_bptr == 2'd0, boeq0);
    check_bit("boeq3", m_bptr == 2'd3, boeq3);
  endtask

  // Model updates on the edge and compares 2 ns before the next one
  initial begin : compare_proc
    forever begin
      @(posedge LLWS);
      update_model();
      #18;
      compare_outputs();
    end
  end

  initial begin : timeout_proc
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] r;
    logic [31:0] packed_w;
    logic [31:0] words [$];

    for (int i = 0; i < FIFO_DEPTH; i++) begin
      m_mem[i]   = '0;
      m_known[i] = '0;
    end
    drive_idle();
    id    = '0;
    rst_n = 1'b0;
    repeat (8) @(posedge LLWS);
    #2;
    rst_n = 1'b1;

    // 1. Full longword loads and read back in order
    test_name = "round_trip";
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      take_bits(32, w);
      words.push_back(w);
      push_word(w);
    end
    check_bit("fifo_full", 1'b1, fifo_full);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      check_word("od", words[i], od);  // Write order
      pop_word();
    end
    check_bit("fifo_empty", 1'b1, fifo_empty);

    // 2. SCSI byte packing in big-endian order
    test_name = "byte_pack";
    inc_bo = 1'b1;  // Off the first lane so the preset has work to do
    step_cycle();
    check_bit("boeq0", 1'b0, boeq0);
    acr_wr = 1'b1;
    h_0c   = 1'b1;
    mid25  = 1'b0;
    step_cycle();
    check_bit("boeq0", 1'b1, boeq0);
    packed_w = '0;
    for (int b = 0; b < LANES; b++) begin
      take_bits(8, r);
      packed_w = {packed_w[23:0], r[7:0]};  // First byte ends up on top
      if (b == LANES - 1) check_bit("boeq3", 1'b1, boeq3);
      id = {4{r[7:0]}};  // Same byte on every lane
      lbyte_n = 1'b0;
      inc_bo  = 1'b1;
      if (b == LANES - 1) begin
        inc_ni   = 1'b1;  // Last byte still lands in the old slot
        inc_fifo = 1'b1;
      end
      step_cycle();
    end
    check_bit("boeq0", 1'b1, boeq0);  // Wrapped
    check_word("od", packed_w, od);
    pop_word();

    // 3. Flags and saturation
    test_name = "flags";
    check_bit("fifo_empty", 1'b1, fifo_empty);
    dec_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_empty", 1'b1, fifo_empty);  // No underflow
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      inc_fifo = 1'b1;
      step_cycle();
    end
    check_bit("fifo_full", 1'b1, fifo_full);
    inc_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_full", 1'b1, fifo_full);  // No overflow
    inc_fifo = 1'b1;
    dec_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_full", 1'b1, fifo_full);
    dec_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_full", 1'b0, fifo_full);  // Count 7
    inc_fifo = 1'b1;
    dec_fifo = 1'b1;
    step_cycle();
    inc_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_full", 1'b1, fifo_full);  // Proves 7 was kept
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      dec_fifo = 1'b1;
      step_cycle();
    end
    check_bit("fifo_empty", 1'b1, fifo_empty);
    inc_fifo = 1'b1;
    dec_fifo = 1'b1;
    step_cycle();
    check_bit("fifo_empty", 1'b1, fifo_empty);

    // 4. ACR preset at $0C
    test_name = "acr_preset";
    acr_wr = 1'b1;
    h_0c   = 1'b1;
    mid25  = 1'b1;
    step_cycle();
    check_bit("bo1", 1'b1, bo1);
    check_bit("bo0", 1'b0, bo0);
    inc_bo = 1'b1;
    step_cycle();
    check_bit("boeq3", 1'b1, boeq3);
    acr_wr = 1'b1;
    h_0c   = 1'b1;
    mid25  = 1'b1;
    inc_bo = 1'b1;  // Load wins
    step_cycle();
    check_bit("bo1", 1'b1, bo1);
    check_bit("bo0", 1'b0, bo0);
    acr_wr = 1'b1;  // Wrong address
    mid25  = 1'b0;
    step_cycle();
    check_bit("bo1", 1'b1, bo1);
    check_bit("bo0", 1'b0, bo0);

    // 5. Half-word and byte load together with the pointer on lane 1
    test_name = "mixed_lanes";
    take_bits(32, a);
    id = a;
    lhword  = 1'b1;  // Lanes 3 2 1
    lbyte_n = 1'b0;
    inc_bo  = 1'b1;
    step_cycle();
    take_bits(32, w);
    id = w;
    lbyte_n  = 1'b0;  // Lane 0
    inc_bo   = 1'b1;
    inc_ni   = 1'b1;
    inc_fifo = 1'b1;
    step_cycle();
    check_word("od", {a[31:8], w[7:0]}, od);
    pop_word();

    // 6. Controller clear
    test_name = "fifo_clear";
    take_bits(32, w);
    push_word(w);
    inc_bo = 1'b1;
    step_cycle();
    check_bit("boeq0", 1'b0, boeq0);
    rst_fifo_n = 1'b0;
    step_cycle();
    check_bit("fifo_empty", 1'b1, fifo_empty);
    check_bit("fifo_full", 1'b0, fifo_full);
    check_bit("boeq0", 1'b1, boeq0);
    take_bits(32, w);
    push_word(w);
    check_word("od", w, od);  // Both pointers back at slot 0
    pop_word();
    check_bit("fifo_empty", 1'b1, fifo_empty);

    step_cycle();
    step_cycle();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+test
verilog/dma_fifo_pkg.sv
verilog/fifo_lane_decode.sv
verilog/fifo_store.sv
verilog/fifo_occupancy.sv
verilog/dma_fifo.sv
test/tb_dma_fifo.sv

// File: Makefile
# Verilator build and run of the DMA FIFO testbench

SIM  := obj_dir/Vtb_dma_fifo
SRCS := $(filter-out +%,$(shell cat list.f)) test/tb_fifo_model.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_dma_fifo -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
